// File: wmux_cfg_pkg.sv
// Design sizes of the AXI write mux, shared by every RTL stage and by the testbench
`default_nettype none

package wmux_cfg_pkg;

  // ------------------------------
  // Ports and ID split
  // ------------------------------
  localparam int unsigned num_ports  = 4;
  localparam int unsigned port_idx_w = $clog2(num_ports);  // Bits added above the ID
  localparam int unsigned slv_id_w   = 4;                  // ID width on the manager ports
  localparam int unsigned mst_id_w   = slv_id_w + port_idx_w;

  // ------------------------------
  // Payload widths
  // ------------------------------
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;

  // Index of one manager port
  typedef logic [port_idx_w-1:0] port_idx_t;

endpackage

`default_nettype wire

// File: wmux_chan_pkg.sv
// AW, W and B payload structs and the two views of the master ID, used by all mux stages
`default_nettype none

package wmux_chan_pkg;

  // Master ID read as source port above the original ID
  typedef struct packed {
    wmux_cfg_pkg::port_idx_t           port;
    logic [wmux_cfg_pkg::slv_id_w-1:0] id;
  } mst_id_fields_t;

  typedef union packed {
    logic [wmux_cfg_pkg::mst_id_w-1:0] flat;
    mst_id_fields_t                    fields;
  } mst_id_u;

  // ------------------------------
  // Address write
  // ------------------------------
  typedef struct packed {
    logic [wmux_cfg_pkg::slv_id_w-1:0] id;
    logic [wmux_cfg_pkg::addr_w-1:0]   addr;
    logic [7:0]                        len;   // Beats minus one
  } slv_aw_t;

  typedef struct packed {
    logic [wmux_cfg_pkg::mst_id_w-1:0] id;    // Flat view of mst_id_u
    logic [wmux_cfg_pkg::addr_w-1:0]   addr;
    logic [7:0]                        len;
  } mst_aw_t;

  // Write data, same on both sides
  typedef struct packed {
    logic [wmux_cfg_pkg::data_w-1:0]   data;
    logic [wmux_cfg_pkg::data_w/8-1:0] strb;
    logic                              last;
  } w_beat_t;

  // ------------------------------
  // Write response
  // ------------------------------
  typedef struct packed {
    logic [wmux_cfg_pkg::slv_id_w-1:0] id;
    logic [1:0]                        resp;
  } slv_b_t;

  typedef struct packed {
    logic [wmux_cfg_pkg::mst_id_w-1:0] id;
    logic [1:0]                        resp;
  } mst_b_t;

endpackage

`default_nettype wire

// File: w_route_fifo.sv
// FIFO of source port indices, one per issued AW, that orders the W bursts
`timescale 1ns/100ps
`default_nettype none

module w_route_fifo #(
  parameter int unsigned Depth = 8
) (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    push_i,
  input  wire wmux_cfg_pkg::port_idx_t data_i,
  output logic                         full_o,
  input  wire logic                    pop_i,
  output wmux_cfg_pkg::port_idx_t      data_o,
  output logic                         empty_o
);

  localparam int unsigned ptr_w = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned cnt_w = $clog2(Depth + 1);

  wmux_cfg_pkg::port_idx_t mem [Depth];
  logic [ptr_w-1:0]        rd_ptr_q, wr_ptr_q;
  logic [cnt_w-1:0]        count_q;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == cnt_w'(Depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem[rd_ptr_q];  // Head, valid from the cycle after its push

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

  // Issue stage must respect full, W stage must respect empty
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o) else $error("Route FIFO push while full");
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o) else $error("Route FIFO pop while empty");

endmodule

`default_nettype wire

// File: aw_arbiter.sv
// Round-robin AW arbiter with lock-in, widens each granted ID with its port index
`timescale 1ns/100ps
`default_nettype none

module aw_arbiter (
  input  wire logic                                                 clk_i,
  input  wire logic                                                 arst_n_i,
  // Manager ports
  input  wire wmux_chan_pkg::slv_aw_t [wmux_cfg_pkg::num_ports-1:0] port_aw_i,
  input  wire logic [wmux_cfg_pkg::num_ports-1:0]                   port_aw_valid_i,
  output logic [wmux_cfg_pkg::num_ports-1:0]                        port_aw_ready_o,
  // Toward the issue stage
  output wmux_chan_pkg::mst_aw_t                                    aw_o,
  output logic                                                      aw_valid_o,
  input  wire logic                                                 aw_ready_i
);

  localparam wmux_cfg_pkg::port_idx_t last_port =
    wmux_cfg_pkg::port_idx_t'(wmux_cfg_pkg::num_ports - 1);

  wmux_cfg_pkg::port_idx_t rr_q;        // Port with the highest priority
  wmux_cfg_pkg::port_idx_t rr_sel;      // First requester at or after rr_q
  wmux_cfg_pkg::port_idx_t sel;
  wmux_cfg_pkg::port_idx_t lock_idx_q;
  logic                    lock_q;
  wmux_chan_pkg::mst_id_u  id_wide;

  // ------------------------------
  // Grant selection
  // ------------------------------
  always_comb begin
    logic        found;
    int unsigned idx;
    found  = 1'b0;
    rr_sel = rr_q;
    for (int unsigned k = 0; k < wmux_cfg_pkg::num_ports; k++) begin
      idx = (rr_q + k) % wmux_cfg_pkg::num_ports;
      if (!found && port_aw_valid_i[idx]) begin
        found  = 1'b1;
        rr_sel = wmux_cfg_pkg::port_idx_t'(idx);
      end
    end
  end

  // A stalled grant stays on its port until taken
  assign sel        = lock_q ? lock_idx_q : rr_sel;
  assign aw_valid_o = port_aw_valid_i[sel];

  always_comb begin
    port_aw_ready_o      = '0;
    port_aw_ready_o[sel] = aw_ready_i;
  end

  // Port index goes above the manager's own ID
  always_comb begin
    id_wide.fields.port = sel;
    id_wide.fields.id   = port_aw_i[sel].id;
  end

  assign aw_o = '{id:   id_wide.flat,
                  addr: port_aw_i[sel].addr,
                  len:  port_aw_i[sel].len};

  // ------------------------------
  // Priority and lock state
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (aw_valid_o) begin
      if (aw_ready_i) begin
        lock_q <= 1'b0;
        rr_q   <= (sel == last_port) ? '0 : sel + 1'b1;  // Skip past the winner
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: aw_issue.sv
// AW issue stage: pushes each grant into the W route FIFO once and drives the master AW
`timescale 1ns/100ps
`default_nettype none

module aw_issue #(
  parameter int unsigned MaxWTrans = 8,
  parameter bit          SpillAw   = 1'b1
) (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  // Granted request
  input  wire wmux_chan_pkg::mst_aw_t aw_i,
  input  wire logic                   aw_valid_i,
  output logic                        aw_ready_o,
  // Master AW
  output wmux_chan_pkg::mst_aw_t      mst_aw_o,
  output logic                        mst_aw_valid_o,
  input  wire logic                   mst_aw_ready_i,
  // Route FIFO head for the W stage
  output wmux_cfg_pkg::port_idx_t     route_idx_o,
  output logic                        route_empty_o,
  input  wire logic                   route_pop_i
);

  logic                   issue_valid, issue_ready;
  logic                   lock_q, lock_d;
  logic                   fifo_full, fifo_push;
  wmux_chan_pkg::mst_id_u aw_id;

  // ------------------------------
  // Lock control
  // ------------------------------
  always_comb begin
    lock_d      = lock_q;
    fifo_push   = 1'b0;
    issue_valid = 1'b0;
    aw_ready_o  = 1'b0;
    if (lock_q) begin
      // Route already pushed, only the handshake is left
      issue_valid = 1'b1;
      if (issue_ready) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && !fifo_full) begin
      issue_valid = 1'b1;
      fifo_push   = 1'b1;
      aw_ready_o  = issue_ready;
      lock_d      = !issue_ready;  // Hold without pushing again
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  assign aw_id.flat = aw_i.id;

  w_route_fifo #(
    .Depth ( MaxWTrans )
  ) i_w_route_fifo (
    .clk_i    ( clk_i             ),
    .arst_n_i ( arst_n_i          ),
    .push_i   ( fifo_push         ),
    .data_i   ( aw_id.fields.port ),
    .full_o   ( fifo_full         ),
    .pop_i    ( route_pop_i       ),
    .data_o   ( route_idx_o       ),
    .empty_o  ( route_empty_o     )
  );

  // ------------------------------
  // Output register
  // ------------------------------
  if (SpillAw) begin : gen_spill
    logic                   a_full_q, b_full_q;
    logic                   a_fill, a_drain, b_fill, b_drain;
    wmux_chan_pkg::mst_aw_t a_data_q, b_data_q;

    assign issue_ready = !a_full_q || !b_full_q;
    assign a_fill      = issue_valid && issue_ready;
    assign a_drain     = a_full_q && !b_full_q;        // Leaves to output or to b
    assign b_fill      = a_drain && !mst_aw_ready_i;
    assign b_drain     = b_full_q && mst_aw_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        a_full_q <= a_fill || (a_full_q && !a_drain);
        b_full_q <= b_fill || (b_full_q && !b_drain);
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) a_data_q <= aw_i;
      if (b_fill) b_data_q <= a_data_q;
    end

    assign mst_aw_valid_o = a_full_q || b_full_q;
    assign mst_aw_o       = b_full_q ? b_data_q : a_data_q;  // Older entry first
  end else begin : gen_bypass
    assign issue_ready    = mst_aw_ready_i;
    assign mst_aw_valid_o = issue_valid;
    assign mst_aw_o       = aw_i;
  end

  // Stalled master AW holds its payload, whichever output path is built
  a_mst_aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
    else $error("Master AW changed while stalled");

endmodule

`default_nettype wire

// File: w_steer.sv
// W steering: forwards the beats of the port at the route FIFO head to the master W
`timescale 1ns/100ps
`default_nettype none

module w_steer (
  // Manager ports
  input  wire wmux_chan_pkg::w_beat_t [wmux_cfg_pkg::num_ports-1:0] port_w_i,
  input  wire logic [wmux_cfg_pkg::num_ports-1:0]                   port_w_valid_i,
  output logic [wmux_cfg_pkg::num_ports-1:0]                        port_w_ready_o,
  // Route FIFO head
  input  wire wmux_cfg_pkg::port_idx_t                              route_idx_i,
  input  wire logic                                                 route_empty_i,
  output logic                                                      route_pop_o,
  // Master W
  output wmux_chan_pkg::w_beat_t                                    mst_w_o,
  output logic                                                      mst_w_valid_o,
  input  wire logic                                                 mst_w_ready_i
);

  assign mst_w_o = port_w_i[route_idx_i];

  always_comb begin
    mst_w_valid_o  = 1'b0;
    port_w_ready_o = '0;
    route_pop_o    = 1'b0;
    // Nothing passes until an AW has named the port
    if (!route_empty_i) begin
      mst_w_valid_o               = port_w_valid_i[route_idx_i];
      port_w_ready_o[route_idx_i] = mst_w_ready_i;
      route_pop_o = port_w_valid_i[route_idx_i] && mst_w_ready_i && mst_w_o.last;  // Burst done
    end
  end

endmodule

`default_nettype wire

// File: b_return.sv
// B return stage of the write mux that sends each master response to the port in its upper ID bits
`timescale 1ns/100ps
`default_nettype none

module b_return (
  input  wire logic                                           clk_i,
  input  wire logic                                           arst_n_i,
  // Master B
  input  wire wmux_chan_pkg::mst_b_t                          mst_b_i,
  input  wire logic                                           mst_b_valid_i,
  output logic                                                mst_b_ready_o,
  // Manager ports
  output wmux_chan_pkg::slv_b_t [wmux_cfg_pkg::num_ports-1:0] port_b_o,
  output logic [wmux_cfg_pkg::num_ports-1:0]                  port_b_valid_o,
  input  wire logic [wmux_cfg_pkg::num_ports-1:0]             port_b_ready_i
);

  wmux_chan_pkg::mst_id_u b_id;

  assign b_id.flat = mst_b_i.id;

  // Every port sees the stripped response, only one sees valid
  for (genvar i = 0; i < wmux_cfg_pkg::num_ports; i++) begin : gen_port_b
    assign port_b_o[i] = '{id: b_id.fields.id, resp: mst_b_i.resp};
  end

  always_comb begin
    port_b_valid_o                    = '0;
    port_b_valid_o[b_id.fields.port] = mst_b_valid_i;
  end

  assign mst_b_ready_o = port_b_ready_i[b_id.fields.port];

  // Subordinate holds a stalled response
  a_b_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_b_valid_i && !mst_b_ready_o |=> mst_b_valid_i && $stable(mst_b_i))
    else $error("Master B changed while stalled");

endmodule

`default_nettype wire

// File: axi_write_mux.sv
// Top of the AXI write mux: merges the manager write channels onto one subordinate port
`timescale 1ns/100ps
`default_nettype none

module axi_write_mux #(
  parameter int unsigned MaxWTrans = 8,     // Issued AWs waiting for W data
  parameter bit          SpillAw   = 1'b1   // Register the master AW
) (
  input  wire logic                                                 clk_i,
  input  wire logic                                                 arst_n_i,
  // ------------------------------
  // Manager ports
  // ------------------------------
  input  wire wmux_chan_pkg::slv_aw_t [wmux_cfg_pkg::num_ports-1:0] port_aw_i,
  input  wire logic [wmux_cfg_pkg::num_ports-1:0]                   port_aw_valid_i,
  output logic [wmux_cfg_pkg::num_ports-1:0]                        port_aw_ready_o,
  input  wire wmux_chan_pkg::w_beat_t [wmux_cfg_pkg::num_ports-1:0] port_w_i,
  input  wire logic [wmux_cfg_pkg::num_ports-1:0]                   port_w_valid_i,
  output logic [wmux_cfg_pkg::num_ports-1:0]                        port_w_ready_o,
  output wmux_chan_pkg::slv_b_t [wmux_cfg_pkg::num_ports-1:0]       port_b_o,
  output logic [wmux_cfg_pkg::num_ports-1:0]                        port_b_valid_o,
  input  wire logic [wmux_cfg_pkg::num_ports-1:0]                   port_b_ready_i,
  // ------------------------------
  // Subordinate port
  // ------------------------------
  output wmux_chan_pkg::mst_aw_t                                    mst_aw_o,
  output logic                                                      mst_aw_valid_o,
  input  wire logic                                                 mst_aw_ready_i,
  output wmux_chan_pkg::w_beat_t                                    mst_w_o,
  output logic                                                      mst_w_valid_o,
  input  wire logic                                                 mst_w_ready_i,
  input  wire wmux_chan_pkg::mst_b_t                                mst_b_i,
  input  wire logic                                                 mst_b_valid_i,
  output logic                                                      mst_b_ready_o
);

  wmux_chan_pkg::mst_aw_t  arb_aw;
  logic                    arb_aw_valid, arb_aw_ready;
  wmux_cfg_pkg::port_idx_t route_idx;
  logic                    route_empty, route_pop;

  aw_arbiter i_aw_arbiter (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .port_aw_i       ( port_aw_i       ),
    .port_aw_valid_i ( port_aw_valid_i ),
    .port_aw_ready_o ( port_aw_ready_o ),
    .aw_o            ( arb_aw          ),
    .aw_valid_o      ( arb_aw_valid    ),
    .aw_ready_i      ( arb_aw_ready    )
  );

  aw_issue #(
    .MaxWTrans ( MaxWTrans ),
    .SpillAw   ( SpillAw   )
  ) i_aw_issue (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .aw_i           ( arb_aw         ),
    .aw_valid_i     ( arb_aw_valid   ),
    .aw_ready_o     ( arb_aw_ready   ),
    .mst_aw_o       ( mst_aw_o       ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .route_idx_o    ( route_idx      ),
    .route_empty_o  ( route_empty    ),
    .route_pop_i    ( route_pop      )
  );

  w_steer i_w_steer (
    .port_w_i       ( port_w_i       ),
    .port_w_valid_i ( port_w_valid_i ),
    .port_w_ready_o ( port_w_ready_o ),
    .route_idx_i    ( route_idx      ),
    .route_empty_i  ( route_empty    ),
    .route_pop_o    ( route_pop      ),
    .mst_w_o        ( mst_w_o        ),
    .mst_w_valid_o  ( mst_w_valid_o  ),
    .mst_w_ready_i  ( mst_w_ready_i  )
  );

  b_return i_b_return (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .mst_b_i        ( mst_b_i        ),
    .mst_b_valid_i  ( mst_b_valid_i  ),
    .mst_b_ready_o  ( mst_b_ready_o  ),
    .port_b_o       ( port_b_o       ),
    .port_b_valid_o ( port_b_valid_o ),
    .port_b_ready_i ( port_b_ready_i )
  );

endmodule

`default_nettype wire

// File: axi_write_mux_tb.sv
// Self-checking testbench for the AXI write mux that plays managers and subordinate from the case file
`timescale 1ns/100ps
`default_nettype none

module axi_write_mux_tb;

  localparam int unsigned num_ports   = wmux_cfg_pkg::num_ports;
  localparam int unsigned max_w_trans = 8;
  localparam int unsigned max_cases   = 64;

  logic clk = 1'b0;
  logic arst_n;

  wmux_chan_pkg::slv_aw_t [num_ports-1:0] port_aw;
  wmux_chan_pkg::w_beat_t [num_ports-1:0] port_w;
  wmux_chan_pkg::slv_b_t  [num_ports-1:0] port_b;
  logic [num_ports-1:0] port_aw_valid, port_aw_ready, port_w_valid, port_w_ready;
  logic [num_ports-1:0] port_b_valid, port_b_ready;
  wmux_chan_pkg::mst_aw_t mst_aw, aw_hold;
  wmux_chan_pkg::w_beat_t mst_w;
  wmux_chan_pkg::mst_b_t  mst_b;
  logic mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready, mst_b_valid, mst_b_ready;

  // Case table with six hex words per burst
  logic [31:0] case_mem [6*max_cases];
  logic [31:0] c_port [max_cases], c_id [max_cases], c_addr [max_cases];
  logic [31:0] c_len [max_cases], c_seed [max_cases], c_resp [max_cases];
  logic [wmux_cfg_pkg::mst_id_w-1:0] rec_id [max_cases];  // ID as seen on the master AW
  bit   aw_seen [max_cases];
  int   num_cases;

  // ------------------------------
  // Reference model state
  // ------------------------------
  int aw_todo [num_ports][$];  // Bursts a port has yet to request
  int w_todo  [num_ports][$];  // Accepted AWs whose data the port still owes
  int exp_aw  [$];             // Accepted AWs not yet seen on the master side
  int w_beat_m [num_ports];
  int w_order [$];             // Acceptance order, which is also master AW order
  int b_order [$];
  int sub_beat, b_done, aw_accepts, last_aw_port;
  int check_count, error_count, cycles, cycle_limit;
  bit rand_ready, w_enable, check_rr, aw_stall_q;

  always #50 clk = ~clk;

  axi_write_mux #(
    .MaxWTrans ( max_w_trans ),
    .SpillAw   ( 1'b1        )
  ) i_axi_write_mux (
    .clk_i           ( clk           ),
    .arst_n_i        ( arst_n        ),
    .port_aw_i       ( port_aw       ),
    .port_aw_valid_i ( port_aw_valid ),
    .port_aw_ready_o ( port_aw_ready ),
    .port_w_i        ( port_w        ),
    .port_w_valid_i  ( port_w_valid  ),
    .port_w_ready_o  ( port_w_ready  ),
    .port_b_o        ( port_b        ),
    .port_b_valid_o  ( port_b_valid  ),
    .port_b_ready_i  ( port_b_ready  ),
    .mst_aw_o        ( mst_aw        ),
    .mst_aw_valid_o  ( mst_aw_valid  ),
    .mst_aw_ready_i  ( mst_aw_ready  ),
    .mst_w_o         ( mst_w         ),
    .mst_w_valid_o   ( mst_w_valid   ),
    .mst_w_ready_i   ( mst_w_ready   ),
    .mst_b_i         ( mst_b         ),
    .mst_b_valid_i   ( mst_b_valid   ),
    .mst_b_ready_o   ( mst_b_ready   )
  );

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic logic pick_ready();
    return !rand_ready || ($urandom % 4 != 0);  // Stalls about one cycle in four
  endfunction

  task automatic read_cases();
    for (int i = 0; i < 6 * max_cases; i++) begin
      case_mem[i] = ~32'(i);  // Never a valid port, so unread words end the table
    end
    $readmemh("axi_write_mux_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < max_cases && case_mem[6*num_cases] < num_ports) begin
      c_port[num_cases] = case_mem[6*num_cases];
      c_id[num_cases]   = case_mem[6*num_cases+1];
      c_addr[num_cases] = case_mem[6*num_cases+2];
      c_len[num_cases]  = case_mem[6*num_cases+3];
      c_seed[num_cases] = case_mem[6*num_cases+4];
      c_resp[num_cases] = case_mem[6*num_cases+5];
      num_cases++;
    end
  endtask

  task automatic load_cases();
    for (int p = 0; p < num_ports; p++) begin
      w_beat_m[p] = 0;
    end
    for (int c = 0; c < num_cases; c++) begin
      aw_todo[c_port[c]].push_back(c);
      aw_seen[c] = 1'b0;
    end
    b_done       = 0;
    aw_accepts   = 0;
    sub_beat     = 0;
    last_aw_port = -1;
  endtask

  // ------------------------------
  // Drive managers and subordinate on the falling edge
  // ------------------------------
  task automatic drive_inputs();
    int c;
    for (int p = 0; p < num_ports; p++) begin
      port_aw_valid[p] = 1'b0;
      port_aw[p]       = '0;
      if (aw_todo[p].size() > 0) begin
        c = aw_todo[p][0];
        port_aw_valid[p] = 1'b1;
        port_aw[p].id    = c_id[c][wmux_cfg_pkg::slv_id_w-1:0];
        port_aw[p].addr  = c_addr[c];
        port_aw[p].len   = c_len[c][7:0];
      end
      port_w_valid[p] = 1'b0;
      port_w[p]       = '0;
      if (w_enable && w_todo[p].size() > 0) begin
        c = w_todo[p][0];
        port_w_valid[p] = 1'b1;
        port_w[p].data  = c_seed[c] + 32'(w_beat_m[p]);  // Beat k carries seed plus k
        port_w[p].strb  = '1;
        port_w[p].last  = (w_beat_m[p] == c_len[c]);
      end
      port_b_ready[p] = pick_ready();
    end
    mst_aw_ready = pick_ready();
    mst_w_ready  = pick_ready();
    mst_b_valid  = 1'b0;
    mst_b        = '0;
    // Responses go back in AW order, once the burst is complete
    if (b_order.size() > 0 && aw_seen[b_order[0]]) begin
      c = b_order[0];
      mst_b_valid = 1'b1;
      mst_b.id    = rec_id[c];
      mst_b.resp  = c_resp[c][1:0];
    end
  endtask

  // ------------------------------
  // Record transfers just before the rising edge
  // ------------------------------
  task automatic sample_outputs();
    int c;
    int p;
    for (int i = 0; i < num_ports; i++) begin
      if (port_aw_valid[i] && port_aw_ready[i]) begin
        c = aw_todo[i].pop_front();
        exp_aw.push_back(c);
        w_todo[i].push_back(c);
        w_order.push_back(c);
        aw_accepts++;
      end
      if (port_w_valid[i] && port_w_ready[i]) begin
        c = w_todo[i][0];
        if (w_beat_m[i] == c_len[c]) begin
          void'(w_todo[i].pop_front());
          w_beat_m[i] = 0;
        end else begin
          w_beat_m[i]++;
        end
      end
    end
    if (aw_stall_q) begin
      check_eq(64'(mst_aw_valid), 64'(1), "master AW valid dropped while stalled");
      check_eq(64'(mst_aw), 64'(aw_hold), "master AW payload changed while stalled");
    end
    aw_stall_q = mst_aw_valid && !mst_aw_ready;
    aw_hold    = mst_aw;
    if (mst_aw_valid && mst_aw_ready) begin
      if (exp_aw.size() == 0) begin
        report_error("master AW arrived with no accepted port AW waiting");
      end else begin
        c = exp_aw.pop_front();
        p = int'(c_port[c]);
        check_eq(64'(mst_aw.id[wmux_cfg_pkg::mst_id_w-1 -: wmux_cfg_pkg::port_idx_w]),
                 64'(p), "AW upper ID bits");
        check_eq(64'(mst_aw.id[wmux_cfg_pkg::slv_id_w-1:0]), 64'(c_id[c]), "AW lower ID bits");
        check_eq(64'(mst_aw.addr), 64'(c_addr[c]), "AW address");
        check_eq(64'(mst_aw.len), 64'(c_len[c]), "AW burst length");
        rec_id[c]  = mst_aw.id;
        aw_seen[c] = 1'b1;
        if (check_rr && last_aw_port >= 0) begin
          check_eq(64'(p), 64'((last_aw_port + 1) % num_ports), "AW round-robin order");
        end
        last_aw_port = p;
      end
    end
    if (mst_w_valid && mst_w_ready) begin
      if (w_order.size() == 0) begin
        report_error("master W beat arrived with no burst waiting");
      end else begin
        c = w_order[0];
        check_eq(64'(mst_w.data), 64'(c_seed[c] + 32'(sub_beat)), "W data");
        check_eq(64'(mst_w.last), 64'(sub_beat == c_len[c]), "W last");
        if (sub_beat == c_len[c]) begin
          void'(w_order.pop_front());
          b_order.push_back(c);
          sub_beat = 0;
        end else begin
          sub_beat++;
        end
      end
    end
    if (mst_b_valid && mst_b_ready) begin
      c = b_order.pop_front();
      p = int'(c_port[c]);
      check_eq(64'(port_b_valid), 64'(1) << p, "B valid port");
      check_eq(64'(port_b_ready[p]), 64'(1), "B taken while its port stalls");
      check_eq(64'(port_b[p].id), 64'(c_id[c]), "B ID");
      check_eq(64'(port_b[p].resp), 64'(c_resp[c]), "B response");
      b_done++;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    drive_inputs();
    #40;  // Settled, and no input changes before the rising edge
    sample_outputs();
  endtask

  task automatic run_test(input string name, input bit random_ready, input bit rr_check);
    int errs_before;
    errs_before = error_count;
    rand_ready  = random_ready;
    check_rr    = rr_check;
    w_enable    = 1'b1;
    load_cases();
    while (b_done < num_cases) begin
      run_cycle();
    end
    $display("Test %s finished with %0d errors", name, error_count - errs_before);
  endtask

  task automatic run_limit_test();
    int errs_before;
    errs_before = error_count;
    rand_ready  = 1'b0;
    check_rr    = 1'b0;
    w_enable    = 1'b0;  // Managers hold W back
    load_cases();
    while (aw_accepts < max_w_trans) begin
      run_cycle();
    end
    repeat (4 * num_ports) begin
      run_cycle();
    end
    check_eq(64'(aw_accepts), 64'(max_w_trans), "port AWs accepted with W held idle");
    w_enable = 1'b1;
    while (b_done < num_cases) begin
      run_cycle();
    end
    $display("Test outstanding limit finished with %0d errors", error_count - errs_before);
  endtask

  // Watchdog
  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(8819));
    arst_n        = 1'b0;
    port_aw       = '0;
    port_aw_valid = '0;
    port_w        = '0;
    port_w_valid  = '0;
    port_b_ready  = '0;
    mst_aw_ready  = 1'b0;
    mst_w_ready   = 1'b0;
    mst_b         = '0;
    mst_b_valid   = 1'b0;
    aw_stall_q    = 1'b0;
    read_cases();
    if (num_cases == 0) begin
      report_error("no cases were read from axi_write_mux_cases.txt");
    end
    cycle_limit = 40 * 3 * num_cases + 200;  // Three passes over the case list
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    run_test("fairness and routing", 1'b0, 1'b1);
    run_test("random back-pressure", 1'b1, 1'b0);
    run_limit_test();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_write_mux_cases.txt
// One write burst per line, all values hex
// Columns: port  id  addr  len  data_seed  resp
0 3 00001000 03 a0000000 0
1 5 00002000 00 b1000000 0
2 a 00003000 07 c2000000 2
3 f 00004000 01 d3000000 0
0 0 00005000 00 a0000100 0
1 5 00006000 05 b1000100 1
2 2 00007000 02 c2000100 0
3 f 00008000 07 d3000100 2
0 9 00009000 06 a0000200 3
1 1 0000a000 01 b1000200 0
2 a 0000b000 00 c2000200 0
3 4 0000c000 03 d3000200 1
0 3 0000d000 02 a0000300 0
1 e 0000e000 07 b1000300 2
2 6 0000f000 04 c2000300 0
3 f 00010000 00 d3000300 0
0 c 00011000 01 a0000400 2
1 5 00012000 03 b1000400 0
2 a 00013000 05 c2000400 3
3 8 00014000 02 d3000400 0
0 7 00015000 04 a0000500 0
1 b 00016000 02 b1000500 0
2 d 00017000 01 c2000500 1
3 0 00018000 06 d3000500 0

// File: axi_write_mux.f
wmux_cfg_pkg.sv
wmux_chan_pkg.sv
w_route_fifo.sv
aw_arbiter.sv
aw_issue.sv
w_steer.sv
b_return.sv
axi_write_mux.sv
axi_write_mux_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the AXI write mux testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module axi_write_mux_tb -f axi_write_mux.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/Vaxi_write_mux_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
